// ==== verilog.f ====
+incdir+rtl
+incdir+verification
rtl/bridgePkg.sv
rtl/apbBus.sv
rtl/ahbSlaveIf.sv
rtl/apbFsmController.sv
rtl/apbRegBank.sv
rtl/apbSlaveArray.sv
rtl/ahbApbSubsystem.sv
verification/ahbApbTb.sv

// ==== verification/ahbMasterTasks.svh ====
/*
 * AHB master tasks
 * Pipelined writes, single reads and a write with a read in its data
 * phase, plus the scoreboard that mirrors the three register banks
 */
`ifndef AHB_MASTER_TASKS_SVH
`define AHB_MASTER_TASKS_SVH

logic [`DATA_WIDTH-1:0] scoreboard [`NUM_SLAVES][`BANK_DEPTH];
logic [`DATA_WIDTH-1:0] burstData [4];

function automatic logic [`ADDR_WIDTH-1:0] wordAddr(input int bank, input int index);
	logic [`ADDR_WIDTH-1:0] base;
	case (bank)
		0: base = `SLAVE_BASE_0;
		1: base = `SLAVE_BASE_1;
		default: base = `SLAVE_BASE_2;
	endcase
	return base + (index << 2);
endfunction

// Returns at the first rising edge that sees Hreadyout high
task automatic waitReady();
	do
		@(posedge Hclk);
	while (Hreadyout !== 1'b1);
endtask

task automatic writeBurst(input int bank, input int start, input int count);
	@(negedge Hclk);
	Haddr = wordAddr(bank, start);
	Htrans = NONSEQ;
	Hwrite = 1'b1;
	Hwdata = ~burstData[0]; // Real word comes in the data phase
	for (int i = 0; i < count; i++)
	begin
		waitReady(); // Address i taken, data i-1 done
		@(negedge Hclk);
		if (i + 1 < count)
		begin
			Haddr = wordAddr(bank, start + i + 1);
			Htrans = SEQ;
		end
		else
			Htrans = IDLE;
		Hwdata = burstData[i];
		scoreboard[bank][start + i] = burstData[i];
	end
	waitReady();
endtask

task automatic ahbRead(input int bank, input int index,
	output logic [`DATA_WIDTH-1:0] data, output int latency);
	@(negedge Hclk);
	Haddr = wordAddr(bank, index);
	Htrans = NONSEQ;
	Hwrite = 1'b0;
	waitReady();
	@(negedge Hclk);
	Htrans = IDLE;
	latency = 0;
	do
	begin
		@(posedge Hclk);
		latency++;
	end
	while (Hreadyout !== 1'b1);
	data = Hrdata;
endtask

task automatic writeThenRead(input int bank, input int index,
	input logic [`DATA_WIDTH-1:0] data, output logic [`DATA_WIDTH-1:0] rdata);
	@(negedge Hclk);
	Haddr = wordAddr(bank, index);
	Htrans = NONSEQ;
	Hwrite = 1'b1;
	Hwdata = ~data;
	waitReady();
	@(negedge Hclk);
	Hwrite = 1'b0; // Read address during the write data phase
	Hwdata = data;
	scoreboard[bank][index] = data;
	waitReady();
	@(negedge Hclk);
	Htrans = IDLE;
	waitReady();
	rdata = Hrdata;
endtask

`endif

// ==== verification/ahbApbTb.sv ====
/*
 * AHB to APB subsystem testbench
 * Drives single, pipelined and ignored AHB transfers into the bridge,
 * checks read data against a scoreboard, read latency and APB phases
 */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module ahbApbTb
	import bridgePkg::*;
();

	localparam int resetCycles = 2;
	localparam int readLatency = 2; // Edges from address taken to read data
	localparam int transferCount = 6 + 8 + 6 + 3 + `NUM_SLAVES * `BANK_DEPTH;
	localparam int cycleLimit = 40 * transferCount + resetCycles + 8;

	logic Hclk;
	logic Hresetn;
	logic [`ADDR_WIDTH-1:0] Haddr;
	logic [1:0] Htrans;
	logic Hwrite;
	logic [`DATA_WIDTH-1:0] Hwdata;
	logic Hreadyin;
	logic [`DATA_WIDTH-1:0] Hrdata;
	logic Hreadyout;
	logic Hresp;

	int valueErrors = 0;
	int protocolErrors = 0;
	int cycles = 0;
	int seed = 32'h04f8_b083;

	`include "ahbMasterTasks.svh"

	ahbApbSubsystem ahbApbSubsystem_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Hwdata(Hwdata),
		.Hreadyin(Hreadyin),
		.Hrdata(Hrdata),
		.Hreadyout(Hreadyout),
		.Hresp(Hresp)
	);

	wire [`NUM_SLAVES-1:0] pselx = ahbApbSubsystem_i.apb.Pselx;
	wire penable = ahbApbSubsystem_i.apb.Penable;

	initial
	begin
		Hclk = 1'b0;
		forever #2 Hclk = ~Hclk;
	end

	// ENABLE must follow a SETUP with the same select
	property enableAfterSetup;
		@(posedge Hclk) disable iff (!Hresetn)
		penable |-> (!$past(penable) && ($past(pselx) == pselx) && (pselx != '0));
	endproperty

	assert property (enableAfterSetup)
	else
	begin
		protocolErrors++;
		$display("Penable went high without a matching SETUP cycle at %0t", $time);
	end

	assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(pselx))
	else
	begin
		protocolErrors++;
		$display("Pselx has more than one bit set: %h", pselx);
	end

	assert property (@(posedge Hclk) Hresp == 1'b0)
	else
	begin
		valueErrors++;
		$display("MISMATCH Hresp: expected %h, got %h", 1'b0, Hresp);
	end

	task automatic checkRead(input int bank, input int index);
		logic [`DATA_WIDTH-1:0] data;
		int latency;
		ahbRead(bank, index, data, latency);
		assert (data === scoreboard[bank][index])
		else
		begin
			valueErrors++;
			$display("MISMATCH Hrdata bank %0d index %0d: expected %h, got %h",
				bank, index, scoreboard[bank][index], data);
		end
		assert (latency == readLatency)
		else
		begin
			protocolErrors++;
			$display("Read from bank %0d took %0d edges instead of %0d",
				bank, latency, readLatency);
		end
	endtask

	// Must not select a bank or stall the master
	task automatic ignoredTransfer(input logic [`ADDR_WIDTH-1:0] addr, input logic [1:0] trans);
		@(negedge Hclk);
		Haddr = addr;
		Htrans = trans;
		Hwrite = 1'b1;
		Hwdata = $random(seed);
		waitReady();
		@(negedge Hclk);
		Htrans = IDLE;
		Hwdata = $random(seed); // Would-be write data
		repeat (2)
		begin
			@(posedge Hclk);
			assert (Hreadyout === 1'b1 && pselx == '0)
			else
			begin
				protocolErrors++;
				$display("Ignored transfer to %h stalled the bus or selected a bank", addr);
			end
		end
	endtask

	initial
	begin
		while (cycles < cycleLimit)
		begin
			@(posedge Hclk);
			cycles++;
		end
		$display("Timeout after %0d cycles, a transfer never completed", cycleLimit);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		int bank;
		int index;
		int start;
		logic [`DATA_WIDTH-1:0] data;
		logic [`DATA_WIDTH-1:0] rdata;
		Hresetn = 1'b0;
		Haddr = '0;
		Htrans = IDLE;
		Hwrite = 1'b0;
		Hwdata = '0;
		Hreadyin = 1'b1;
		for (int b = 0; b < `NUM_SLAVES; b++)
			for (int i = 0; i < `BANK_DEPTH; i++)
				scoreboard[b][i] = '0;
		repeat (resetCycles) @(posedge Hclk);
		@(negedge Hclk);
		Hresetn = 1'b1;
		repeat (2)
		begin
			@(posedge Hclk);
			assert (pselx == '0 && !penable)
			else
			begin
				protocolErrors++;
				$display("APB select or enable active before the first transfer");
			end
		end
		assert (Hreadyout === 1'b1)
		else
		begin
			protocolErrors++;
			$display("Hreadyout did not rise within two cycles of reset");
		end

		for (bank = 0; bank < `NUM_SLAVES; bank++)
		begin
			index = $random(seed) & (`BANK_DEPTH - 1);
			burstData[0] = $random(seed);
			writeBurst(bank, index, 1);
			checkRead(bank, index);
		end

		ignoredTransfer(wordAddr(1, 3), IDLE);
		ignoredTransfer(32'h1000_0040, NONSEQ);
		ignoredTransfer(32'h8C00_0008, SEQ); // Just above the last region

		bank = {$random(seed)} % `NUM_SLAVES;
		start = {$random(seed)} % (`BANK_DEPTH - 3);
		for (int i = 0; i < 4; i++)
			burstData[i] = $random(seed);
		writeBurst(bank, start, 4);
		for (int i = 0; i < 4; i++)
			checkRead(bank, start + i);

		for (bank = 0; bank < `NUM_SLAVES; bank++)
		begin
			index = $random(seed) & (`BANK_DEPTH - 1);
			data = $random(seed);
			writeThenRead(bank, index, data, rdata);
			assert (rdata === data)
			else
			begin
				valueErrors++;
				$display("MISMATCH Hrdata after write, bank %0d index %0d: expected %h, got %h",
					bank, index, data, rdata);
			end
		end

		// Full read-back also shows the ignored transfers left the banks alone
		for (bank = 0; bank < `NUM_SLAVES; bank++)
			for (index = 0; index < `BANK_DEPTH; index++)
				checkRead(bank, index);

		$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== rtl/ahbApbSubsystem.sv ====
/*
 * AHB to APB subsystem
 * AHB slave front end, APB controller and three APB register banks
 * behind one AHB slave port
 */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module ahbApbSubsystem
(
	input logic Hclk,
	input logic Hresetn,
	input logic [`ADDR_WIDTH-1:0] Haddr,
	input logic [1:0] Htrans,
	input logic Hwrite,
	input logic [`DATA_WIDTH-1:0] Hwdata,
	input logic Hreadyin,
	output logic [`DATA_WIDTH-1:0] Hrdata,
	output logic Hreadyout,
	output logic Hresp
);

	logic valid;
	logic [`ADDR_WIDTH-1:0] Haddr1;
	logic [`ADDR_WIDTH-1:0] Haddr2;
	logic [`DATA_WIDTH-1:0] Hwdata1;
	logic [`DATA_WIDTH-1:0] Hwdata2;
	logic Hwritereg;
	logic [`NUM_SLAVES-1:0] tempselx;

	apbBus apb();

	ahbSlaveIf ahbSlaveIf_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Hwdata(Hwdata),
		.Hreadyin(Hreadyin),
		.valid(valid),
		.Haddr1(Haddr1),
		.Haddr2(Haddr2),
		.Hwdata1(Hwdata1),
		.Hwdata2(Hwdata2),
		.Hwritereg(Hwritereg),
		.tempselx(tempselx)
	);

	apbFsmController apbFsmController_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.valid(valid),
		.Haddr(Haddr),
		.Haddr1(Haddr1),
		.Haddr2(Haddr2),
		.Hwdata(Hwdata),
		.Hwdata1(Hwdata1),
		.Hwdata2(Hwdata2),
		.Hwrite(Hwrite),
		.Hwritereg(Hwritereg),
		.tempselx(tempselx),
		.apb(apb.master),
		.Hreadyout(Hreadyout)
	);

	apbSlaveArray apbSlaveArray_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.apb(apb.slave)
	);

	assign Hrdata = apb.Prdata;
	assign Hresp = 1'b0; // OKAY

endmodule

// ==== rtl/apbSlaveArray.sv ====
/*
 * APB peripheral array
 * Three register banks, one per select line, and the read data mux
 */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module apbSlaveArray
(
	input logic Hclk,
	input logic Hresetn,
	apbBus.slave apb
);

	logic [`DATA_WIDTH-1:0] bankRdata [`NUM_SLAVES];

	for (genvar i = 0; i < `NUM_SLAVES; i++)
	begin : genBank
		apbRegBank bank_i
		(
			.Hclk(Hclk),
			.Hresetn(Hresetn),
			.psel(apb.Pselx[i]),
			.penable(apb.Penable),
			.pwrite(apb.Pwrite),
			.paddr(apb.Paddr),
			.pwdata(apb.Pwdata),
			.prdata(bankRdata[i])
		);
	end

	// Select is one-hot, so OR-ing the gated banks picks one
	always_comb
	begin
		apb.Prdata = '0;
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			if (apb.Pselx[i])
				apb.Prdata = apb.Prdata | bankRdata[i];
		end
	end

endmodule

// ==== rtl/apbRegBank.sv ====
/*
 * APB register bank
 * One peripheral with BANK_DEPTH word registers, written at the end
 * of the ENABLE phase and read with no wait states
 */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module apbRegBank
(
	input logic Hclk,
	input logic Hresetn,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`ADDR_WIDTH-1:0] paddr,
	input logic [`DATA_WIDTH-1:0] pwdata,
	output logic [`DATA_WIDTH-1:0] prdata
);

	localparam int indexBits = $clog2(`BANK_DEPTH);

	logic [`DATA_WIDTH-1:0] regs [`BANK_DEPTH];
	logic [indexBits-1:0] index;
	logic writeEn;

	assign index = paddr[indexBits+1:2]; // Word index
	assign writeEn = psel && penable && pwrite;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			for (int i = 0; i < `BANK_DEPTH; i++)
				regs[i] <= '0;
		end
		else if (writeEn)
			regs[index] <= pwdata;
	end

	assign prdata = regs[index];

endmodule

// ==== rtl/apbFsmController.sv ====
/*
 * APB controller
 * Eight-state machine that turns accepted AHB transfers into APB
 * SETUP and ENABLE phases, keeps back-to-back writes in order and
 * stalls the AHB master through Hreadyout
 */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module apbFsmController
	import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic valid,
	input logic [`ADDR_WIDTH-1:0] Haddr,
	input logic [`ADDR_WIDTH-1:0] Haddr1,
	input logic [`ADDR_WIDTH-1:0] Haddr2,
	input logic [`DATA_WIDTH-1:0] Hwdata,
	input logic [`DATA_WIDTH-1:0] Hwdata1,
	input logic [`DATA_WIDTH-1:0] Hwdata2,
	input logic Hwrite,
	input logic Hwritereg,
	input logic [`NUM_SLAVES-1:0] tempselx,
	apbBus.master apb,
	output logic Hreadyout
);

	apbStateT state;
	apbStateT nextState;

	logic accept;
	logic [`NUM_SLAVES-1:0] pendSel;
	logic [`ADDR_WIDTH-1:0] paddrNext;
	logic [`DATA_WIDTH-1:0] pwdataNext;
	logic pwriteNext;
	logic penableNext;
	logic [`NUM_SLAVES-1:0] pselNext;
	logic readyNext;

	assign accept = valid && Hreadyout; // Address phase taken this edge

	always_comb
	begin
		nextState = state;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				if (accept && Hwrite)
					nextState = stWwait;
				else if (accept)
					nextState = stRead;
				else
					nextState = stIdle;
			end
			stWwait:
				nextState = accept ? stWriteP : stWrite;
			stRead:
				nextState = stRenable;
			stWrite:
				nextState = stWenable;
			stWriteP:
				nextState = stWenableP;
			stWenableP:
			begin
				// Ready low here means the pending transfer is a read
				if (!Hreadyout)
					nextState = stRead;
				else if (accept)
					nextState = stWriteP;
				else
					nextState = stWrite;
			end
			default:
				nextState = stIdle;
		endcase
	end

	always_comb
	begin
		paddrNext = apb.Paddr;
		pwdataNext = apb.Pwdata;
		pwriteNext = apb.Pwrite;
		pselNext = apb.Pselx;
		penableNext = 1'b0;
		readyNext = 1'b1;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				if (accept && !Hwrite)
				begin
					paddrNext = Haddr; // Read goes straight to SETUP
					pwriteNext = 1'b0;
					pselNext = tempselx;
					readyNext = 1'b0;
				end
				else
					pselNext = '0;
			end
			stWwait:
			begin
				paddrNext = Haddr1;
				pwdataNext = Hwdata;
				pwriteNext = 1'b1;
				pselNext = pendSel;
				readyNext = 1'b0;
			end
			stRead:
				penableNext = 1'b1;
			stWrite, stWriteP:
			begin
				penableNext = 1'b1; // Address and data hold from SETUP
				if (state == stWriteP)
					readyNext = Hwritereg; // Hold a pending read
			end
			stWenableP:
			begin
				paddrNext = Haddr2; // Transfer accepted during the last write
				pwdataNext = Hwdata1;
				pwriteNext = Hreadyout;
				pselNext = pendSel;
				readyNext = 1'b0;
			end
			default:
				pselNext = '0;
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state <= stIdle;
			apb.Pselx <= '0;
			apb.Penable <= 1'b0;
			apb.Pwrite <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			state <= nextState;
			apb.Pselx <= pselNext;
			apb.Penable <= penableNext;
			apb.Pwrite <= pwriteNext;
			Hreadyout <= readyNext;
		end
	end

	always_ff @(posedge Hclk)
	begin
		apb.Paddr <= paddrNext;
		apb.Pwdata <= pwdataNext;
		if (accept)
			pendSel <= tempselx; // Select of the newest accepted transfer
	end

endmodule

// ==== rtl/ahbSlaveIf.sv ====
/*
 * AHB slave front end
 * Pipelines the address, write data and direction, flags valid
 * transfers and decodes the address into a one-hot peripheral select
 */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module ahbSlaveIf
	import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic [`ADDR_WIDTH-1:0] Haddr,
	input logic [1:0] Htrans,
	input logic Hwrite,
	input logic [`DATA_WIDTH-1:0] Hwdata,
	input logic Hreadyin,
	output logic valid,
	output logic [`ADDR_WIDTH-1:0] Haddr1,
	output logic [`ADDR_WIDTH-1:0] Haddr2,
	output logic [`DATA_WIDTH-1:0] Hwdata1,
	output logic [`DATA_WIDTH-1:0] Hwdata2,
	output logic Hwritereg,
	output logic [`NUM_SLAVES-1:0] tempselx
);

	localparam logic [`ADDR_WIDTH-1:0] slaveBase [`NUM_SLAVES] =
		'{`SLAVE_BASE_0, `SLAVE_BASE_1, `SLAVE_BASE_2};

	logic activeTrans;

	always_ff @(posedge Hclk)
	begin
		Haddr1 <= Haddr;
		Haddr2 <= Haddr1;
		Hwdata1 <= Hwdata;
		Hwdata2 <= Hwdata1;
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			Hwritereg <= 1'b0;
		else
			Hwritereg <= Hwrite;
	end

	// Region match on the bits above the 64 MB window
	always_comb
	begin
		tempselx = '0;
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			if (Haddr[`ADDR_WIDTH-1:`REGION_LSB] ==
				slaveBase[i][`ADDR_WIDTH-1:`REGION_LSB])
				tempselx[i] = 1'b1;
		end
	end

	assign activeTrans = (Htrans == NONSEQ) || (Htrans == SEQ);

	assign valid = Hreadyin && activeTrans && (|tempselx); // Unmapped is ignored

endmodule

// ==== rtl/apbBus.sv ====
/*
 * APB bus
 * Carries one transfer from the bridge controller to the peripheral
 * array, with a one-hot peripheral select
 */
`timescale 1ns/1ps
`include "bridge_macros.svh"

interface apbBus;

	logic [`ADDR_WIDTH-1:0] Paddr;
	logic [`DATA_WIDTH-1:0] Pwdata;
	logic [`DATA_WIDTH-1:0] Prdata;
	logic Pwrite;
	logic Penable;
	logic [`NUM_SLAVES-1:0] Pselx; // One-hot, zero when idle

	modport master
	(
		output Paddr, Pwdata, Pwrite, Penable, Pselx,
		input Prdata
	);

	modport slave
	(
		input Paddr, Pwdata, Pwrite, Penable, Pselx,
		output Prdata
	);

endinterface

// ==== rtl/bridgePkg.sv ====
/*
 * Bridge types
 * AHB transfer types and the APB controller state encoding
 */
package bridgePkg;

	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htransT;

	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100,
		stRenable  = 3'b101,
		stWenable  = 3'b110,
		stWenableP = 3'b111
	} apbStateT;

endpackage

// ==== rtl/bridge_macros.svh ====
/*
 * AHB to APB bridge parameters
 * Bus widths, the peripheral address map and the register bank depth
 */
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32

`define NUM_SLAVES 3

// Three 64 MB regions, decoded on the upper address bits
`define REGION_LSB 26
`define SLAVE_BASE_0 32'h8000_0000
`define SLAVE_BASE_1 32'h8400_0000
`define SLAVE_BASE_2 32'h8800_0000

// Words per bank, indexed by address bits 5:2
`define BANK_DEPTH 16

`endif
